//--- hw/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int INST_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int IMM_W     = 20;

    typedef logic [INST_W-1:0]    inst_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMM_W-1:0]     imm20_t;

    // major opcodes, bits [6:0]
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;

    // funct7 forms
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    // sub and arithmetic right shift
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    typedef enum logic [3:0] {
        int_reg,
        int_imm,
        upper,
        jump,
        branch,
        load,
        store,
        muldiv,
        unknown
    } inst_class_e;

    typedef enum logic [4:0] {
        none,
        // alu
        lui,
        add,
        sub,
        addw,
        subw,
        sll,
        srl,
        sra,
        sllw,
        srlw,
        sraw,
        op_xor,
        op_or,
        op_and,
        slt,
        sltu,
        // mdu
        mul,
        mulw,
        mulh,
        mulhu,
        mulhsu,
        div,
        divw,
        divu,
        rem,
        remw,
        remu,
        remuw
    } micro_op_e;

    typedef enum logic [1:0] {
        alu,
        mdu,
        bru,
        lsu
    } issue_unit_e;

    typedef enum logic [1:0] {
        int_block,
        mem_block,
        unknown_block
    } disp_block_e;

    typedef struct packed {
        micro_op_e   micro_op;
        issue_unit_e issue_unit;
        disp_block_e disp_block;
        reg_idx_t    rd_idx;
        reg_idx_t    rs1_idx;
        reg_idx_t    rs2_idx;
        logic        rd_wen;
        logic        rs1_ren;
        logic        rs2_ren;
        // immediate takes the rs2 operand slot
        logic        use_imm;
        imm20_t      imm20;
        logic        unknown;
    } dec_info_t;

endpackage

`default_nettype wire

//--- hw/inst_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module inst_classifier
    import decode_pkg::*;
(
    input  inst_t       i_inst,
    output inst_class_e o_class,
    output micro_op_e   o_micro_op,
    output issue_unit_e o_issue_unit,
    output disp_block_e o_disp_block
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       full_len;

    assign opcode   = i_inst[6:0];
    assign funct3   = i_inst[14:12];
    assign funct7   = i_inst[31:25];
    assign full_len = &i_inst[1:0];

    always_comb begin
        o_class    = unknown;
        o_micro_op = none;
        case (opcode)
            OPC_OP: begin
                case (funct7)
                    F7_BASE: begin
                        case (funct3)
                            3'b000: o_micro_op = add;
                            3'b001: o_micro_op = sll;
                            3'b010: o_micro_op = slt;
                            3'b011: o_micro_op = sltu;
                            3'b100: o_micro_op = op_xor;
                            3'b101: o_micro_op = srl;
                            3'b110: o_micro_op = op_or;
                            default: o_micro_op = op_and;
                        endcase
                    end
                    F7_ALT: begin
                        if (funct3 == 3'b000) begin
                            o_micro_op = sub;
                        end else if (funct3 == 3'b101) begin
                            o_micro_op = sra;
                        end
                    end
                    F7_MULDIV: begin
                        case (funct3)
                            3'b000: o_micro_op = mul;
                            3'b001: o_micro_op = mulh;
                            3'b010: o_micro_op = mulhsu;
                            3'b011: o_micro_op = mulhu;
                            3'b100: o_micro_op = div;
                            3'b101: o_micro_op = divu;
                            3'b110: o_micro_op = rem;
                            default: o_micro_op = remu;
                        endcase
                    end
                    default: ;
                endcase
            end
            OPC_OP_32: begin
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}:   o_micro_op = addw;
                    {F7_BASE, 3'b001}:   o_micro_op = sllw;
                    {F7_BASE, 3'b101}:   o_micro_op = srlw;
                    {F7_ALT, 3'b000}:    o_micro_op = subw;
                    {F7_ALT, 3'b101}:    o_micro_op = sraw;
                    {F7_MULDIV, 3'b000}: o_micro_op = mulw;
                    {F7_MULDIV, 3'b100}: o_micro_op = divw;
                    {F7_MULDIV, 3'b110}: o_micro_op = remw;
                    {F7_MULDIV, 3'b111}: o_micro_op = remuw;
                    // divuw has no micro-op and stays unknown
                    default: ;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: o_micro_op = add;
                    3'b010: o_micro_op = slt;
                    3'b011: o_micro_op = sltu;
                    3'b100: o_micro_op = op_xor;
                    3'b110: o_micro_op = op_or;
                    3'b111: o_micro_op = op_and;
                    // rv64 shifts, funct7[0] is shamt[5]
                    3'b001: o_micro_op = (funct7[6:1] == 6'b000000) ? sll : none;
                    default: begin
                        if (funct7[6:1] == F7_BASE[6:1]) begin
                            o_micro_op = srl;
                        end else if (funct7[6:1] == F7_ALT[6:1]) begin
                            o_micro_op = sra;
                        end
                    end
                endcase
            end
            OPC_OP_IMM_32: begin
                case ({funct7, funct3}) inside
                    {7'b???????, 3'b000}: o_micro_op = addw;
                    {F7_BASE, 3'b001}:    o_micro_op = sllw;
                    {F7_BASE, 3'b101}:    o_micro_op = srlw;
                    {F7_ALT, 3'b101}:     o_micro_op = sraw;
                    default: ;
                endcase
            end
            OPC_LUI: begin
                o_class    = upper;
                o_micro_op = lui;
            end
            OPC_AUIPC: begin
                o_class    = upper;
                o_micro_op = add;
            end
            OPC_JAL: o_class = jump;
            OPC_JALR: o_class = (funct3 == 3'b000) ? jump : unknown;
            OPC_BRANCH: o_class = (funct3[2:1] == 2'b01) ? unknown : branch;
            OPC_LOAD: o_class = (funct3 == 3'b111) ? unknown : load;
            OPC_STORE: o_class = funct3[2] ? unknown : store;
            default: ;
        endcase

        // arithmetic class follows from a matched micro-op
        if (o_micro_op != none) begin
            if (opcode == OPC_OP || opcode == OPC_OP_32) begin
                o_class = (funct7 == F7_MULDIV) ? muldiv : int_reg;
            end else if (opcode == OPC_OP_IMM || opcode == OPC_OP_IMM_32) begin
                o_class = int_imm;
            end
        end

        // 16-bit encodings
        if (!full_len) begin
            o_class    = unknown;
            o_micro_op = none;
        end
    end

    always_comb begin
        o_disp_block = int_block;
        case (o_class)
            int_reg, int_imm, upper: o_issue_unit = alu;
            muldiv: o_issue_unit = mdu;
            load, store: begin
                o_issue_unit = lsu;
                o_disp_block = mem_block;
            end
            unknown: begin
                o_issue_unit = bru;
                o_disp_block = unknown_block;
            end
            default: o_issue_unit = bru;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import decode_pkg::*;
(
    input  inst_t       i_inst,
    input  inst_class_e i_class,
    output imm20_t      o_imm,
    output logic        o_use_imm
);

    imm20_t imm_i;
    imm20_t imm_s;
    imm20_t imm_b;
    imm20_t imm_u;
    imm20_t imm_j;
    imm20_t imm_sh;
    logic   is_shift;
    logic   is_jalr;

    assign imm_i = {{8{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{8{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{8{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    // shifted left by 12 at execute
    assign imm_u = i_inst[31:12];
    // bit 20 of the offset is dropped
    assign imm_j = {i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    // funct3 001 or 101
    assign is_shift = (i_inst[13:12] == 2'b01);
    assign imm_sh   = (i_inst[6:0] == OPC_OP_IMM) ? {14'd0, i_inst[25:20]}
                                                  : {15'd0, i_inst[24:20]};
    assign is_jalr  = (i_inst[6:0] == OPC_JALR);

    always_comb begin
        case (i_class)
            upper:   o_imm = imm_u;
            branch:  o_imm = imm_b;
            store:   o_imm = imm_s;
            load:    o_imm = imm_i;
            jump:    o_imm = is_jalr ? imm_i : imm_j;
            int_imm: o_imm = is_shift ? imm_sh : imm_i;
            default: o_imm = '0;
        endcase
    end

    assign o_use_imm = (i_class == int_imm);

endmodule

`default_nettype wire

//--- hw/reg_usage.sv
`timescale 1ns/1ps
`default_nettype none

module reg_usage
    import decode_pkg::*;
(
    input  inst_t       i_inst,
    input  inst_class_e i_class,
    output reg_idx_t    o_rd_idx,
    output reg_idx_t    o_rs1_idx,
    output reg_idx_t    o_rs2_idx,
    output logic        o_rd_wen,
    output logic        o_rs1_ren,
    output logic        o_rs2_ren
);

    logic is_jal;
    logic has_rd;
    logic has_rs1;
    logic has_rs2;

    assign is_jal = (i_inst[6:0] == OPC_JAL);

    // unused fields reported as x0
    assign has_rd  = !(i_class inside {branch, store, unknown});
    assign has_rs1 = !(is_jal || i_class inside {upper, unknown});
    assign has_rs2 = i_class inside {int_reg, muldiv, branch, store};

    assign o_rd_idx  = has_rd ? i_inst[11:7] : '0;
    assign o_rs1_idx = has_rs1 ? i_inst[19:15] : '0;
    assign o_rs2_idx = has_rs2 ? i_inst[24:20] : '0;

    // x0 is never read or written
    assign o_rd_wen  = |o_rd_idx;
    assign o_rs1_ren = |o_rs1_idx;
    assign o_rs2_ren = |o_rs2_idx;

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import decode_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    input  inst_t     i_inst,
    input  logic      i_valid,
    input  logic      i_ready,
    output logic      o_ready,
    output logic      o_valid,
    output dec_info_t o_dec
);

    inst_class_e inst_class;
    micro_op_e   micro_op;
    issue_unit_e issue_unit;
    disp_block_e disp_block;
    imm20_t      imm;
    logic        use_imm;
    reg_idx_t    rd_idx;
    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    logic        rd_wen;
    logic        rs1_ren;
    logic        rs2_ren;
    dec_info_t   dec_d;
    dec_info_t   dec_q;
    logic        valid_q;
    logic        accept;

    inst_classifier u_classifier (
        .i_inst       (i_inst),
        .o_class      (inst_class),
        .o_micro_op   (micro_op),
        .o_issue_unit (issue_unit),
        .o_disp_block (disp_block)
    );

    imm_gen u_imm_gen (
        .i_inst    (i_inst),
        .i_class   (inst_class),
        .o_imm     (imm),
        .o_use_imm (use_imm)
    );

    reg_usage u_reg_usage (
        .i_inst    (i_inst),
        .i_class   (inst_class),
        .o_rd_idx  (rd_idx),
        .o_rs1_idx (rs1_idx),
        .o_rs2_idx (rs2_idx),
        .o_rd_wen  (rd_wen),
        .o_rs1_ren (rs1_ren),
        .o_rs2_ren (rs2_ren)
    );

    always_comb begin
        dec_d.micro_op   = micro_op;
        dec_d.issue_unit = issue_unit;
        dec_d.disp_block = disp_block;
        dec_d.rd_idx     = rd_idx;
        dec_d.rs1_idx    = rs1_idx;
        dec_d.rs2_idx    = rs2_idx;
        dec_d.rd_wen     = rd_wen;
        dec_d.rs1_ren    = rs1_ren;
        dec_d.rs2_ren    = rs2_ren;
        dec_d.use_imm    = use_imm;
        dec_d.imm20      = imm;
        dec_d.unknown    = (inst_class == unknown);
    end

    // free when empty or draining this cycle
    assign o_ready = !valid_q || i_ready;
    assign accept  = i_valid && o_ready;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (i_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            dec_q <= dec_d;
        end
    end

    assign o_valid = valid_q;
    assign o_dec   = dec_q;

endmodule

`default_nettype wire

//--- include/decode_ref_model.svh
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// fixed opcode and funct fields, rnd fills rd, rs1 and rs2
function automatic decode_pkg::inst_t build_inst(
    input logic [6:0]  opc,
    input logic [2:0]  f3,
    input logic [6:0]  f7,
    input logic [31:0] rnd
);
    return {f7, rnd[24:15], f3, rnd[11:7], opc};
endfunction

// expected record for a word whose class and micro-op are known
function automatic decode_pkg::dec_info_t expect_dec(
    input decode_pkg::inst_t       inst,
    input decode_pkg::inst_class_e cls,
    input decode_pkg::micro_op_e   uop
);
    decode_pkg::dec_info_t d;
    logic                  is_jal;
    logic                  rv64_op;
    is_jal  = (inst[6:0] == decode_pkg::OPC_JAL);
    rv64_op = (inst[6:0] == decode_pkg::OPC_OP_IMM);
    d = '0;
    d.micro_op   = uop;
    d.unknown    = (cls == decode_pkg::unknown);
    d.disp_block = d.unknown ? decode_pkg::unknown_block : decode_pkg::int_block;
    d.issue_unit = decode_pkg::bru;
    if (cls inside {decode_pkg::load, decode_pkg::store}) begin
        d.issue_unit = decode_pkg::lsu;
        d.disp_block = decode_pkg::mem_block;
    end else if (cls == decode_pkg::muldiv) begin
        d.issue_unit = decode_pkg::mdu;
    end else if (cls inside {decode_pkg::int_reg, decode_pkg::int_imm,
                             decode_pkg::upper}) begin
        d.issue_unit = decode_pkg::alu;
    end
    if (!(cls inside {decode_pkg::branch, decode_pkg::store, decode_pkg::unknown}))
        d.rd_idx = inst[11:7];
    if (!(is_jal || cls inside {decode_pkg::upper, decode_pkg::unknown}))
        d.rs1_idx = inst[19:15];
    if (cls inside {decode_pkg::int_reg, decode_pkg::muldiv, decode_pkg::branch,
                    decode_pkg::store})
        d.rs2_idx = inst[24:20];
    d.rd_wen  = (d.rd_idx != 0);
    d.rs1_ren = (d.rs1_idx != 0);
    d.rs2_ren = (d.rs2_idx != 0);
    d.use_imm = (cls == decode_pkg::int_imm);
    case (cls)
        decode_pkg::upper:  d.imm20 = inst[31:12];
        decode_pkg::branch:
            d.imm20 = 20'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
        decode_pkg::store:  d.imm20 = 20'($signed({inst[31:25], inst[11:7]}));
        decode_pkg::load:   d.imm20 = 20'($signed(inst[31:20]));
        decode_pkg::jump:   d.imm20 = is_jal ? {inst[19:12], inst[20], inst[30:21], 1'b0}
                                             : 20'($signed(inst[31:20]));
        decode_pkg::int_imm: begin
            if (inst[14:12] == 3'b001 || inst[14:12] == 3'b101)
                d.imm20 = rv64_op ? 20'(inst[25:20]) : 20'(inst[24:20]);
            else
                d.imm20 = 20'($signed(inst[31:20]));
        end
        default: d.imm20 = '0;
    endcase
    return d;
endfunction

`endif

//--- test/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage
    import decode_pkg::*;
();

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 5;
    localparam int          DRIVE_DELAY  = 1;
    localparam int          ROUNDS       = 3;
    localparam int          N_HAND       = 120;
    localparam int          N_FULL       = 32;
    localparam logic [31:0] SEED         = 32'hee4c_6bf3;

    // one instruction pattern, masked bits are randomized
    typedef struct packed {
        logic [6:0]  opc;
        logic [6:0]  opc_mask;
        logic [2:0]  f3;
        logic [2:0]  f3_mask;
        logic [6:0]  f7;
        logic [6:0]  f7_mask;
        inst_class_e cls;
        micro_op_e   uop;
    } form_t;

    logic      i_clk = 1'b0;
    logic      i_reset;
    inst_t     i_inst;
    logic      i_valid;
    logic      i_ready;
    logic      o_ready;
    logic      o_valid;
    dec_info_t o_dec;

    form_t     forms[$];
    dec_info_t exp_q[$];
    string     name_q[$];
    dec_info_t cur_exp;
    string     cur_name;
    dec_info_t head_dec;
    string     head_name;
    logic      acc_prev = 1'b0;
    logic      bp_on;
    int        stretch;
    int        cycle = 0;
    int        c0;
    int        n_in = 0;
    int        n_out = 0;
    int        planned = 0;

    `include "decode_ref_model.svh"

    decode_stage u_dut (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_inst  (i_inst),
        .i_valid (i_valid),
        .i_ready (i_ready),
        .o_ready (o_ready),
        .o_valid (o_valid),
        .o_dec   (o_dec)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic fail_plain(input string what);
        $display("%s (cycle %0d)", what, cycle);
        abort_run();
    endtask

    task automatic fail_value(input string test, input logic [63:0] expected,
                              input logic [63:0] actual);
        $display("[ERROR] %s: expected %0h, actual %0h", test, expected, actual);
        abort_run();
    endtask

    task automatic add_form(input logic [6:0] opc, input logic [6:0] opc_mask,
                            input logic [2:0] f3, input logic [2:0] f3_mask,
                            input logic [6:0] f7, input logic [6:0] f7_mask,
                            input inst_class_e cls, input micro_op_e uop);
        forms.push_back('{opc, opc_mask, f3, f3_mask, f7, f7_mask, cls, uop});
    endtask

    task automatic build_forms();
        micro_op_e base_ops [8];
        micro_op_e md_ops [8];
        base_ops = '{add, sll, slt, sltu, op_xor, srl, op_or, op_and};
        md_ops   = '{mul, mulh, mulhsu, mulhu, div, divu, rem, remu};
        for (int k = 0; k < 8; k++) begin
            add_form(OPC_OP, 7'h00, 3'(k), 3'h0, F7_BASE, 7'h00, int_reg, base_ops[k]);
            add_form(OPC_OP, 7'h00, 3'(k), 3'h0, F7_MULDIV, 7'h00, muldiv, md_ops[k]);
            if (k != 1 && k != 5)
                add_form(OPC_OP_IMM, 7'h00, 3'(k), 3'h0, 7'h00, 7'h7f, int_imm, base_ops[k]);
            if (k != 2 && k != 3)
                add_form(OPC_BRANCH, 7'h00, 3'(k), 3'h0, 7'h00, 7'h7f, branch, none);
            if (k != 7)
                add_form(OPC_LOAD, 7'h00, 3'(k), 3'h0, 7'h00, 7'h7f, load, none);
            if (k < 4)
                add_form(OPC_STORE, 7'h00, 3'(k), 3'h0, 7'h00, 7'h7f, store, none);
        end
        add_form(OPC_OP, 7'h00, 3'd0, 3'h0, F7_ALT, 7'h00, int_reg, sub);
        add_form(OPC_OP, 7'h00, 3'd5, 3'h0, F7_ALT, 7'h00, int_reg, sra);
        // bit 25 is shamt[5] in the rv64 forms
        add_form(OPC_OP_IMM, 7'h00, 3'd1, 3'h0, F7_BASE, 7'h01, int_imm, sll);
        add_form(OPC_OP_IMM, 7'h00, 3'd5, 3'h0, F7_BASE, 7'h01, int_imm, srl);
        add_form(OPC_OP_IMM, 7'h00, 3'd5, 3'h0, F7_ALT, 7'h01, int_imm, sra);
        add_form(OPC_OP_32, 7'h00, 3'd0, 3'h0, F7_BASE, 7'h00, int_reg, addw);
        add_form(OPC_OP_32, 7'h00, 3'd0, 3'h0, F7_ALT, 7'h00, int_reg, subw);
        add_form(OPC_OP_32, 7'h00, 3'd1, 3'h0, F7_BASE, 7'h00, int_reg, sllw);
        add_form(OPC_OP_32, 7'h00, 3'd5, 3'h0, F7_BASE, 7'h00, int_reg, srlw);
        add_form(OPC_OP_32, 7'h00, 3'd5, 3'h0, F7_ALT, 7'h00, int_reg, sraw);
        add_form(OPC_OP_32, 7'h00, 3'd0, 3'h0, F7_MULDIV, 7'h00, muldiv, mulw);
        add_form(OPC_OP_32, 7'h00, 3'd4, 3'h0, F7_MULDIV, 7'h00, muldiv, divw);
        add_form(OPC_OP_32, 7'h00, 3'd6, 3'h0, F7_MULDIV, 7'h00, muldiv, remw);
        add_form(OPC_OP_32, 7'h00, 3'd7, 3'h0, F7_MULDIV, 7'h00, muldiv, remuw);
        add_form(OPC_OP_IMM_32, 7'h00, 3'd0, 3'h0, 7'h00, 7'h7f, int_imm, addw);
        add_form(OPC_OP_IMM_32, 7'h00, 3'd1, 3'h0, F7_BASE, 7'h00, int_imm, sllw);
        add_form(OPC_OP_IMM_32, 7'h00, 3'd5, 3'h0, F7_BASE, 7'h00, int_imm, srlw);
        add_form(OPC_OP_IMM_32, 7'h00, 3'd5, 3'h0, F7_ALT, 7'h00, int_imm, sraw);
        add_form(OPC_LUI, 7'h00, 3'd0, 3'h7, 7'h00, 7'h7f, upper, lui);
        add_form(OPC_AUIPC, 7'h00, 3'd0, 3'h7, 7'h00, 7'h7f, upper, add);
        add_form(OPC_JAL, 7'h00, 3'd0, 3'h7, 7'h00, 7'h7f, jump, none);
        add_form(OPC_JALR, 7'h00, 3'd0, 3'h0, 7'h00, 7'h7f, jump, none);
        // compressed, then fp, csr/system, amo and fence opcodes
        add_form(7'b0000000, 7'b1111110, 3'd0, 3'h7, 7'h00, 7'h7f, unknown, none);
        add_form(7'b0000001, 7'b1111100, 3'd0, 3'h7, 7'h00, 7'h7f, unknown, none);
        add_form(7'b0000111, 7'h00, 3'd0, 3'h7, 7'h00, 7'h7f, unknown, none);
        add_form(7'b0100111, 7'h00, 3'd0, 3'h7, 7'h00, 7'h7f, unknown, none);
        add_form(7'b1010011, 7'h00, 3'd0, 3'h7, 7'h00, 7'h7f, unknown, none);
        add_form(7'b1000011, 7'h00, 3'd0, 3'h7, 7'h00, 7'h7f, unknown, none);
        add_form(7'b1110011, 7'h00, 3'd0, 3'h7, 7'h00, 7'h7f, unknown, none);
        add_form(7'b0101111, 7'h00, 3'd0, 3'h7, 7'h00, 7'h7f, unknown, none);
        add_form(7'b0001111, 7'h00, 3'd0, 3'h7, 7'h00, 7'h7f, unknown, none);
    endtask

    // round 0: nonzero registers, negative imm; round 1: x0 everywhere, positive imm
    function automatic inst_t make_word(input form_t f, input int round);
        logic [31:0] r;
        logic [31:0] s;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r = $urandom;
        s = $urandom;
        if (round == 0)
            r = r | 32'h0010_8080;
        else if (round == 1)
            r = r & ~32'h01ff_8f80;
        opc = (f.opc & ~f.opc_mask) | (s[6:0] & f.opc_mask);
        f3  = (f.f3 & ~f.f3_mask) | (s[9:7] & f.f3_mask);
        f7  = (f.f7 & ~f.f7_mask) | (s[16:10] & f.f7_mask);
        if (f.f7_mask[6] && round < 2)
            f7[6] = (round == 0);
        return build_inst(opc, f3, f7, r);
    endfunction

    task automatic send_form(input form_t f, input string phase, input int round);
        inst_t w;
        w        = make_word(f, round);
        cur_exp  = expect_dec(w, f.cls, f.uop);
        cur_name = $sformatf("%s %s %s", phase, f.cls.name(), f.uop.name());
        i_inst   = w;
        i_valid  = 1'b1;
        @(negedge i_clk);
        while (!o_ready) @(negedge i_clk);
        @(posedge i_clk);
        #DRIVE_DELAY;
        i_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge i_clk);
        @(posedge i_clk);
        #DRIVE_DELAY;
    endtask

    // output side is checked before the next acceptance is queued
    always @(negedge i_clk) begin
        cycle++;
        if (i_reset) begin
            assert (!o_valid && o_ready)
                else fail_plain("o_valid high or o_ready low during reset");
            acc_prev = 1'b0;
        end else begin
            if (acc_prev)
                assert (o_valid) else fail_plain("no record one cycle after acceptance");
            if (i_ready)
                assert (o_ready) else fail_plain("o_ready low while i_ready is high");
            if (o_valid && i_ready) begin
                assert (exp_q.size() != 0)
                    else fail_plain("output record without an accepted word");
                head_dec  = exp_q.pop_front();
                head_name = name_q.pop_front();
                n_out++;
                assert (o_dec == head_dec)
                    else fail_value(head_name, 64'(head_dec), 64'(o_dec));
            end
            acc_prev = i_valid && o_ready;
            if (acc_prev) begin
                exp_q.push_back(cur_exp);
                name_q.push_back(cur_name);
                n_in++;
            end
        end
    end

    stall_ready_low: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_valid && !i_ready) |-> !o_ready)
        else fail_plain("o_ready high while the output is stalled");

    stall_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_dec)))
        else fail_plain("output record changed or dropped while stalled");

    // back-pressure with random run lengths
    initial begin
        i_ready = 1'b1;
        stretch = 0;
        forever begin
            @(posedge i_clk);
            #DRIVE_DELAY;
            if (!bp_on) begin
                i_ready = 1'b1;
                stretch = 0;
            end else if (stretch > 0) begin
                stretch--;
            end else begin
                i_ready = !i_ready;
                stretch = $urandom_range(0, 5);
            end
        end
    end

    initial begin
        wait (planned != 0);
        repeat (RESET_CYCLES + 40 * planned) @(posedge i_clk);
        $display("run hung, no completion after %0d cycles", cycle);
        abort_run();
    end

    initial begin
        void'($urandom(SEED));
        i_reset  = 1'b1;
        i_inst   = '0;
        i_valid  = 1'b0;
        bp_on    = 1'b0;
        cur_exp  = '0;
        cur_name = "";
        build_forms();
        planned = ROUNDS * forms.size() + N_HAND + N_FULL;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #DRIVE_DELAY;
        i_reset = 1'b0;
        @(negedge i_clk);
        assert (!o_valid && o_ready)
            else fail_plain("o_valid high or o_ready low after reset");
        @(posedge i_clk);
        #DRIVE_DELAY;

        for (int round = 0; round < ROUNDS; round++) begin
            foreach (forms[k])
                send_form(forms[k], "sweep", round);
        end

        bp_on = 1'b1;
        repeat (N_HAND) begin
            repeat ($urandom_range(0, 2)) begin
                @(posedge i_clk);
                #DRIVE_DELAY;
            end
            send_form(forms[$urandom_range(0, forms.size() - 1)], "handshake",
                      $urandom_range(0, 2));
        end
        bp_on = 1'b0;
        wait_drain();

        // back to back, one word per cycle
        c0 = cycle;
        repeat (N_FULL)
            send_form(forms[$urandom_range(0, forms.size() - 1)], "throughput", 2);
        assert (cycle - c0 == N_FULL)
            else fail_value("throughput cycles", 64'(N_FULL), 64'(cycle - c0));
        wait_drain();
        repeat (2) @(negedge i_clk);

        if (n_out == n_in && exp_q.size() == 0 && !o_valid) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("records accepted %0d, delivered %0d", n_in, n_out);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
hw/decode_pkg.sv
hw/inst_classifier.sv
hw/imm_gen.sv
hw/reg_usage.sv
hw/decode_stage.sv
test/tb_decode_stage.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_decode_stage -f list.f -Mdir obj_dir
	./obj_dir/Vtb_decode_stage

clean:
	rm -rf obj_dir
